// File: common/imuldiv_ctrl_pkg.sv
// ------------------------------
// imuldiv engine control types
// ------------------------------

`default_nettype none

package imuldiv_ctrl_pkg;

  // common engine FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } engine_state_e;

  // divider sub-step inside ST_CALC
  typedef enum logic {
    STEP_SHIFT = 1'b0,
    STEP_FIXUP = 1'b1
  } div_step_e;

endpackage

`default_nettype wire

// File: common/imuldiv_defines.svh
// ------------------------------
// imuldiv shared sizes
// operand width, iteration count and order queue depth
// ------------------------------

`ifndef IMULDIV_DEFINES_SVH
`define IMULDIV_DEFINES_SVH

// operand width in bits
`define IMULDIV_XLEN 32
// one iteration per operand bit
`define IMULDIV_ITERS 32
// one multiply and one divide outstanding
`define IMULDIV_ORDER_DEPTH 2

`endif

// File: common/imuldiv_msg_pkg.sv
// ------------------------------
// imuldiv message types
// opcodes and payload words on the request/response path
// ------------------------------

`default_nettype none

`include "imuldiv_defines.svh"

package imuldiv_msg_pkg;

  // request opcode
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_e;

  // single operand word
  typedef logic [`IMULDIV_XLEN-1:0] operand_t;

  // full result, remainder:quotient for divides
  typedef logic [2*`IMULDIV_XLEN-1:0] result_t;

  // which engine owns an outstanding request
  typedef enum logic {
    UNIT_MUL = 1'b0,
    UNIT_DIV = 1'b1
  } unit_sel_e;

endpackage

`default_nettype wire

// File: div/imuldiv_int_div_iterative.sv
// ------------------------------
// iterative divider
// restoring shift-subtract, signed or unsigned, sign fixup at the end
// ------------------------------

`default_nettype none

`include "imuldiv_defines.svh"

module imuldiv_int_div_iterative (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             req_val,
  output logic                            req_rdy,
  input  wire                             req_signed,
  input  wire  imuldiv_msg_pkg::operand_t req_a,
  input  wire  imuldiv_msg_pkg::operand_t req_b,
  output logic                            resp_val,
  input  wire                             resp_rdy,
  output imuldiv_msg_pkg::result_t        result
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  localparam int XLEN  = `IMULDIV_XLEN;
  localparam int CNT_W = $clog2(`IMULDIV_ITERS);

  engine_state_e    state;
  engine_state_e    state_next;
  div_step_e        step;
  logic [CNT_W-1:0] cnt;
  logic             req_go;

  // datapath
  operand_t  dvsr;
  operand_t  quo;
  operand_t  rem;
  logic      q_neg;
  logic      r_neg;
  operand_t  a_mag;
  operand_t  b_mag;
  logic [XLEN:0] rem_sh;
  logic [XLEN:0] rem_sub;
  logic      fits;
  logic      div_zero;

  assign req_go = req_val && req_rdy;

  // magnitudes only taken for signed divides
  assign a_mag = (req_signed && req_a[XLEN-1]) ? -req_a : req_a;
  assign b_mag = (req_signed && req_b[XLEN-1]) ? -req_b : req_b;

  // shift next dividend bit into the partial remainder, then trial subtract
  assign rem_sh   = {rem, quo[XLEN-1]};
  assign rem_sub  = rem_sh - {1'b0, dvsr};
  assign fits     = (rem_sh >= {1'b0, dvsr});
  assign div_zero = (dvsr == '0);

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      step  <= STEP_SHIFT;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        step <= STEP_SHIFT;
        cnt  <= CNT_W'(`IMULDIV_ITERS - 1);
      end else if (state == ST_CALC && step == STEP_SHIFT) begin
        cnt <= cnt - 1'b1;
        // one more cycle for the signs after the last shift step
        if (cnt == '0) step <= STEP_FIXUP;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (req_val) state_next = ST_CALC;
      ST_CALC: if (step == STEP_FIXUP) state_next = ST_DONE;
      ST_DONE: if (resp_rdy) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  // ------------------------------
  // datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      dvsr  <= b_mag;
      quo   <= a_mag;
      rem   <= '0;
      q_neg <= req_signed & (req_a[XLEN-1] ^ req_b[XLEN-1]);
      r_neg <= req_signed & req_a[XLEN-1];
    end else if (state == ST_CALC) begin
      if (step == STEP_SHIFT) begin
        rem <= fits ? rem_sub[XLEN-1:0] : rem_sh[XLEN-1:0];
        quo <= {quo[XLEN-2:0], fits};
      end else begin
        // with a zero divisor the remainder already holds the dividend magnitude,
        // so the sign step below restores the dividend itself
        quo <= div_zero ? '1 : (q_neg ? -quo : quo);
        rem <= r_neg ? -rem : rem;
      end
    end
  end

  // remainder in the upper half, quotient in the lower
  assign result = {rem, quo};

  accept_idle_a: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |-> (state == ST_IDLE) ##1 (state == ST_CALC && step == STEP_SHIFT));

endmodule

`default_nettype wire

// File: hdl/imuldiv_int_muldiv.sv
// ------------------------------
// multiply/divide unit top
// issue block plus the two iterative engines
// ------------------------------

`default_nettype none

module imuldiv_int_muldiv (
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               req_val,
  output logic                              req_rdy,
  input  wire  imuldiv_msg_pkg::muldiv_fn_e req_fn,
  input  wire  imuldiv_msg_pkg::operand_t   req_a,
  input  wire  imuldiv_msg_pkg::operand_t   req_b,
  output logic                              resp_val,
  input  wire                               resp_rdy,
  output imuldiv_msg_pkg::result_t          resp_result
);

  import imuldiv_msg_pkg::*;

  // engine handshakes
  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  logic    mul_resp_rdy;
  result_t mul_result;
  logic    div_req_val;
  logic    div_req_signed;
  logic    div_req_rdy;
  logic    div_resp_val;
  logic    div_resp_rdy;
  result_t div_result;

  imuldiv_issue_order u_issue (
    .clk            (clk),
    .reset          (reset),
    .req_val        (req_val),
    .req_rdy        (req_rdy),
    .req_fn         (req_fn),
    .resp_val       (resp_val),
    .resp_rdy       (resp_rdy),
    .resp_result    (resp_result),
    .mul_req_val    (mul_req_val),
    .mul_req_rdy    (mul_req_rdy),
    .mul_resp_val   (mul_resp_val),
    .mul_resp_rdy   (mul_resp_rdy),
    .mul_result     (mul_result),
    .div_req_val    (div_req_val),
    .div_req_signed (div_req_signed),
    .div_req_rdy    (div_req_rdy),
    .div_resp_val   (div_resp_val),
    .div_resp_rdy   (div_resp_rdy),
    .div_result     (div_result)
  );

  // operands go straight to both engines, valid picks the one that loads
  imuldiv_int_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req_a    (req_a),
    .req_b    (req_b),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .result   (mul_result)
  );

  imuldiv_int_div_iterative u_div (
    .clk        (clk),
    .reset      (reset),
    .req_val    (div_req_val),
    .req_rdy    (div_req_rdy),
    .req_signed (div_req_signed),
    .req_a      (req_a),
    .req_b      (req_b),
    .resp_val   (div_resp_val),
    .resp_rdy   (div_resp_rdy),
    .result     (div_result)
  );

endmodule

`default_nettype wire

// File: hdl/imuldiv_issue_order.sv
// ------------------------------
// issue and response ordering
// steers requests to an engine, returns responses in request order
// ------------------------------

`default_nettype none

`include "imuldiv_defines.svh"

module imuldiv_issue_order (
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               req_val,
  output logic                              req_rdy,
  input  wire  imuldiv_msg_pkg::muldiv_fn_e req_fn,
  output logic                              resp_val,
  input  wire                               resp_rdy,
  output imuldiv_msg_pkg::result_t          resp_result,
  // multiplier side
  output logic                              mul_req_val,
  input  wire                               mul_req_rdy,
  input  wire                               mul_resp_val,
  output logic                              mul_resp_rdy,
  input  wire  imuldiv_msg_pkg::result_t    mul_result,
  // divider side
  output logic                              div_req_val,
  output logic                              div_req_signed,
  input  wire                               div_req_rdy,
  input  wire                               div_resp_val,
  output logic                              div_resp_rdy,
  input  wire  imuldiv_msg_pkg::result_t    div_result
);

  import imuldiv_msg_pkg::*;

  localparam int DEPTH = `IMULDIV_ORDER_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  unit_sel_e        q_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             q_full;
  logic             q_empty;
  unit_sel_e        tgt;
  unit_sel_e        head;
  logic             push;
  logic             pop;

  // ------------------------------
  // request side
  // ------------------------------

  assign tgt            = (req_fn == FN_MUL) ? UNIT_MUL : UNIT_DIV;
  assign div_req_signed = (req_fn == FN_DIV);

  assign q_full  = (count == CNT_W'(DEPTH));
  assign q_empty = (count == '0);

  // only the addressed engine sees valid, and only while a tag slot is free
  assign mul_req_val = req_val && !q_full && (tgt == UNIT_MUL);
  assign div_req_val = req_val && !q_full && (tgt == UNIT_DIV);
  assign req_rdy     = !q_full && ((tgt == UNIT_MUL) ? mul_req_rdy : div_req_rdy);

  // ------------------------------
  // response side
  // ------------------------------

  assign head         = q_mem[rd_ptr];
  assign resp_val     = !q_empty && ((head == UNIT_MUL) ? mul_resp_val : div_resp_val);
  assign resp_result  = (head == UNIT_MUL) ? mul_result : div_result;
  // the engine not at the head keeps waiting in its done state
  assign mul_resp_rdy = resp_rdy && !q_empty && (head == UNIT_MUL);
  assign div_resp_rdy = resp_rdy && !q_empty && (head == UNIT_DIV);

  assign push = req_val && req_rdy;
  assign pop  = resp_val && resp_rdy;

  // order queue of engine tags
  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= tgt;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  no_overflow_a: assert property (@(posedge clk) disable iff (reset)
    push |-> (count < CNT_W'(DEPTH)));

  no_underflow_a: assert property (@(posedge clk) disable iff (reset)
    pop |-> (count != '0));

endmodule

`default_nettype wire

// File: imuldiv_int_muldiv.f
+incdir+common
common/imuldiv_msg_pkg.sv
common/imuldiv_ctrl_pkg.sv
mul/imuldiv_int_mul_iterative.sv
div/imuldiv_int_div_iterative.sv
hdl/imuldiv_issue_order.sv
hdl/imuldiv_int_muldiv.sv
verif/imuldiv_checker.sv
verif/imuldiv_tb.sv

// File: mul/imuldiv_int_mul_iterative.sv
// ------------------------------
// iterative multiplier
// signed shift-add, one bit of the multiplier per cycle
// ------------------------------

`default_nettype none

`include "imuldiv_defines.svh"

module imuldiv_int_mul_iterative (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             req_val,
  output logic                            req_rdy,
  input  wire  imuldiv_msg_pkg::operand_t req_a,
  input  wire  imuldiv_msg_pkg::operand_t req_b,
  output logic                            resp_val,
  input  wire                             resp_rdy,
  output imuldiv_msg_pkg::result_t        result
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  localparam int XLEN  = `IMULDIV_XLEN;
  localparam int CNT_W = $clog2(`IMULDIV_ITERS);

  engine_state_e    state;
  engine_state_e    state_next;
  logic [CNT_W-1:0] cnt;
  logic             req_go;

  // datapath registers
  result_t  a_reg;
  operand_t b_reg;
  result_t  acc;
  logic     neg;
  operand_t a_mag;
  operand_t b_mag;

  assign req_go = req_val && req_rdy;

  // operand magnitudes, the most negative value maps onto itself as unsigned
  assign a_mag = req_a[XLEN-1] ? -req_a : req_a;
  assign b_mag = req_b[XLEN-1] ? -req_b : req_b;

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      // count 31 down to 0 over the calc phase
      if (req_go) begin
        cnt <= CNT_W'(`IMULDIV_ITERS - 1);
      end else if (state == ST_CALC) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (req_val) state_next = ST_CALC;
      ST_CALC: if (cnt == '0) state_next = ST_DONE;
      ST_DONE: if (resp_rdy) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  // ------------------------------
  // datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      a_reg <= result_t'(a_mag);
      b_reg <= b_mag;
      acc   <= '0;
      neg   <= req_a[XLEN-1] ^ req_b[XLEN-1];
    end else if (state == ST_CALC) begin
      // add shifted multiplicand when the current multiplier bit is set
      if (b_reg[0]) begin
        acc <= acc + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // sign correction on the unsigned product
  assign result = neg ? -acc : acc;

  // held response must not move while the consumer stalls
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(result)));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the imuldiv testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f imuldiv_int_muldiv.f \
  --top-module imuldiv_tb \
  -o imuldiv_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/imuldiv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  exit 1
fi
exit 0

// File: verif/imuldiv_checker.sv
// ------------------------------
// imuldiv response checker
// models results in request order and compares each response
// ------------------------------

`default_nettype none

`include "imuldiv_defines.svh"

module imuldiv_checker (
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               req_val,
  input  wire                               req_rdy,
  input  wire  imuldiv_msg_pkg::muldiv_fn_e req_fn,
  input  wire  imuldiv_msg_pkg::operand_t   req_a,
  input  wire  imuldiv_msg_pkg::operand_t   req_b,
  input  wire                               resp_val,
  input  wire                               resp_rdy,
  input  wire  imuldiv_msg_pkg::result_t    resp_result,
  input  wire                               latency_en,
  output int                                err_count,
  output int                                pending
);

  import imuldiv_msg_pkg::*;

  // one entry per accepted request, head is the oldest
  result_t    exp_q [$];
  muldiv_fn_e fn_q [$];
  operand_t   a_q [$];
  operand_t   b_q [$];
  int         acc_q [$];

  int   errors = 0;
  int   outstanding = 0;
  int   cycle = 0;
  int   lat_exp;
  logic was_reset = 1'b0;
  logic head_seen = 1'b0;

  assign err_count = errors;
  assign pending   = outstanding;

  // reference arithmetic for every opcode
  function automatic result_t expected_result(muldiv_fn_e fn, operand_t a, operand_t b);
    longint   pa;
    longint   pb;
    int       sa;
    int       sb;
    operand_t q;
    operand_t r;
    if (fn == FN_MUL) begin
      pa = {{32{a[31]}}, a};
      pb = {{32{b[31]}}, b};
      return result_t'(pa * pb);
    end
    if (b == '0) begin
      // divide by zero, all ones quotient and the dividend back
      q = '1;
      r = a;
    end else if (fn == FN_DIV) begin
      sa = a;
      sb = b;
      if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        q = a;
        r = '0;
      end else begin
        q = operand_t'(sa / sb);
        r = operand_t'(sa % sb);
      end
    end else begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  // sampled mid-cycle, values hold until the next rising edge
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (reset) begin
      was_reset = 1'b1;
      head_seen = 1'b0;
    end else begin
      // first cycle out of reset
      if (was_reset) begin
        was_reset = 1'b0;
        if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
          $display("error %0t: after reset req_rdy=%b resp_val=%b", $time, req_rdy, resp_val);
          errors++;
        end
      end
      // ------------------------------
      // response side
      // ------------------------------
      if (resp_val && exp_q.size() == 0) begin
        $display("unexpected response at time %0t with no request outstanding", $time);
        errors++;
      end else if (resp_val) begin
        lat_exp = (fn_q[0] == FN_MUL) ? `IMULDIV_ITERS + 1 : `IMULDIV_ITERS + 2;
        if (latency_en && !head_seen && (cycle - acc_q[0]) != lat_exp) begin
          $display("error %0t: %s latency %0d cycles, expected %0d", $time,
                   fn_q[0].name(), cycle - acc_q[0], lat_exp);
          errors++;
        end
        head_seen = 1'b1;
        if (resp_rdy) begin
          if (resp_result !== exp_q[0]) begin
            $display("error %0t: %s a=%h b=%h got %h expected %h", $time,
                     fn_q[0].name(), a_q[0], b_q[0], resp_result, exp_q[0]);
            errors++;
          end
          void'(exp_q.pop_front());
          void'(fn_q.pop_front());
          void'(a_q.pop_front());
          void'(b_q.pop_front());
          void'(acc_q.pop_front());
          head_seen = 1'b0;
        end
      end
      // request side, queued after the pop so order is kept
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
        fn_q.push_back(req_fn);
        a_q.push_back(req_a);
        b_q.push_back(req_b);
        acc_q.push_back(cycle);
      end
    end
    outstanding = exp_q.size();
  end

endmodule

`default_nettype wire

// File: verif/imuldiv_tb.sv
// ------------------------------
// imuldiv testbench
// seeded random requests, back-pressure and per-test summary
// ------------------------------

`default_nettype none

`include "imuldiv_defines.svh"

module imuldiv_tb;

  import imuldiv_msg_pkg::*;

  localparam int N_MUL = 60;
  localparam int N_DIV = 60;
  localparam int N_DIVZ = 8;
  localparam int N_MIX = 80;
  localparam int N_REQ = 3 + N_MUL + 1 + N_DIV + N_DIVZ + N_MIX;
  // 40 cycles per request plus reset and drain margin
  localparam int TIMEOUT_CYCLES = N_REQ * 40 + 300;

  logic       clk;
  logic       reset;
  logic       req_val;
  logic       req_rdy;
  muldiv_fn_e req_fn;
  operand_t   req_a;
  operand_t   req_b;
  logic       resp_val;
  logic       resp_rdy;
  result_t    resp_result;
  logic       latency_en;
  logic       bp_en;
  int         err_count;
  int         pending;
  integer     seed;
  integer     bp_seed;
  int         tests_run;
  int         tests_failed;
  int         err_base;

  imuldiv_int_muldiv UUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  imuldiv_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .latency_en  (latency_en),
    .err_count   (err_count),
    .pending     (pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // random operand, biased toward the corner values
  function automatic operand_t pick_operand();
    int r;
    r = $random(seed);
    case (r & 7)
      0: return '0;
      1: return '1;
      2: return {1'b1, {(`IMULDIV_XLEN - 1){1'b0}}};
      3: return operand_t'($random(seed) % 16);
      default: return operand_t'($random(seed));
    endcase
  endfunction

  function automatic muldiv_fn_e pick_fn();
    int r;
    r = $random(seed);
    case (r & 3)
      0: return FN_MUL;
      1: return FN_DIV;
      2: return FN_DIVU;
      default: return FN_MUL;
    endcase
  endfunction

  // hold the request until the edge where req_rdy is high
  task automatic send_request(input muldiv_fn_e fn, input operand_t a, input operand_t b);
    @(posedge clk);
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  // drain outstanding responses, then report the test
  task automatic end_test(input string name);
    int errs;
    @(posedge clk);
    while (pending != 0) @(posedge clk);
    errs = err_count - err_base;
    err_base = err_count;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  // resp_rdy is random only while back-pressure is on
  always @(posedge clk) begin
    if (bp_en) begin
      resp_rdy <= (($random(bp_seed) & 3) != 0);
    end else begin
      resp_rdy <= 1'b1;
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    seed = 32'h60c3;
    bp_seed = 32'h60c3;
    reset = 1'b1;
    req_val = 1'b0;
    req_fn = FN_MUL;
    req_a = '0;
    req_b = '0;
    resp_rdy = 1'b1;
    latency_en = 1'b0;
    bp_en = 1'b0;
    tests_run = 0;
    tests_failed = 0;
    err_base = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    // isolated requests, one at a time
    latency_en <= 1'b1;
    send_request(FN_MUL, pick_operand(), pick_operand());
    end_test("reset and isolated mul");
    send_request(FN_DIV, pick_operand(), pick_operand());
    end_test("isolated div");
    send_request(FN_DIVU, pick_operand(), pick_operand());
    end_test("isolated divu");
    latency_en <= 1'b0;

    for (int i = 0; i < N_MUL; i++) send_request(FN_MUL, pick_operand(), pick_operand());
    end_test("random signed mul");

    send_request(FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    for (int i = 0; i < N_DIV; i++) send_request(pick_fn() == FN_DIVU ? FN_DIVU : FN_DIV,
                                                 pick_operand(), pick_operand());
    end_test("random div and divu");

    for (int i = 0; i < N_DIVZ; i++) send_request(i[0] ? FN_DIVU : FN_DIV, pick_operand(), '0);
    end_test("divide by zero");

    // mixed traffic with a stalling consumer
    bp_en <= 1'b1;
    for (int i = 0; i < N_MIX; i++) send_request(pick_fn(), pick_operand(), pick_operand());
    end_test("mixed with back-pressure");
    bp_en <= 1'b0;

    $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // hang guard
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, a request or response never completed",
             TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
